/* all.f */
+incdir+verilog
verilog/koaPkg.sv
verilog/koaIf.sv
verilog/koaSplitter.sv
verilog/koaLaneMult.sv
verilog/koaCombiner.sv
verilog/koaSigMult.sv
testbench/tbClockGen.sv
testbench/tbKoaSigMult.sv

/* run.sh */
#!/bin/sh
# Compile and run the Karatsuba multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbKoaSigMult -f all.f -o simKoaSigMult

status=0
./obj_dir/simKoaSigMult > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed (exit status $status)"
exit 1

/* testbench/tbKoaSigMult.sv */
// Directed testbench for the Karatsuba-Ofman significand multiplier
// Reference queue, negedge monitor, compare tasks, watchdog and report

`timescale 1ns/1ns

`include "koa_config.svh"

module tbKoaSigMult;

    localparam int ClkPeriodNs = 8;
    localparam int ResetCycles = 16;
    localparam int StreamLen   = 40;
    localparam int BurstLen    = 8;
    // Corners, latency, stream, hold, burst and the recovery pair
    localparam int NumOps      = 6 + 1 + StreamLen + 2 + BurstLen + 1;
    localparam int WatchdogNs  = (NumOps + 20) * (`KOA_LAT + 4) * ClkPeriodNs;
    // Longest wait for outstanding results
    localparam int DrainLimit  = 2 * `KOA_LAT + 4;

    logic                 clk;
    logic                 porRstN;
    logic                 midRstN;
    logic                 rstN;
    logic                 validIn;
    koaPkg::operand_t     opA;
    koaPkg::operand_t     opB;
    logic                 validOut;
    koaPkg::product_t     productOut;

    // Expected products in acceptance order
    koaPkg::product_t     expQ [$];
    koaPkg::product_t     lastProduct;
    int                   resultCount;
    int                   valueErrors;
    int                   missingErrors;
    int                   unexpectedErrors;

    tbClockGen #(
        .PeriodNs    (ClkPeriodNs),
        .ResetCycles (ResetCycles)
    ) clkGen0 (
        .clk_o  (clk),
        .rstN_o (porRstN)
    );

    // Power-on reset combined with the mid-stream reset
    assign rstN = porRstN & midRstN;

    koaSigMult dut0 (
        .clk       (clk),
        .rstN_i    (rstN),
        .valid_i   (validIn),
        .opA_i     (opA),
        .opB_i     (opB),
        .valid_o   (validOut),
        .product_o (productOut)
    );

    // ====================
    // Reference and compare
    // ====================

    // Plain wide product of the two significands
    function automatic koaPkg::product_t exactProduct(input koaPkg::operand_t a,
                                                      input koaPkg::operand_t b);
        return koaPkg::product_t'(a) * koaPkg::product_t'(b);
    endfunction

    task automatic checkProduct(input koaPkg::product_t actual,
                                input koaPkg::product_t expected, input string what);
        if (actual !== expected) begin
            valueErrors++;
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkValid(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            valueErrors++;
            $display("Fail %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Every valid_o pops one expected product
    always @(negedge clk) begin
        if (validOut === 1'b1) begin
            if (expQ.size() == 0) begin
                unexpectedErrors++;
                $display("%0t ns: a result came out with no pair outstanding", $time);
            end else begin
                lastProduct = expQ.pop_front();
                checkProduct(productOut, lastProduct, "product_o");
                resultCount++;
            end
        end
    end

    // ====================
    // Drive helpers
    // ====================

    // Called just after a rising edge
    task automatic drivePair(input koaPkg::operand_t a, input koaPkg::operand_t b);
        validIn <= 1'b1;
        opA     <= a;
        opB     <= b;
        expQ.push_back(exactProduct(a, b));
    endtask

    task automatic driveIdle();
        validIn <= 1'b0;
    endtask

    task automatic waitDrain(input string what);
        int cycles;
        cycles = 0;
        while (expQ.size() != 0 && cycles < DrainLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (expQ.size() != 0) begin
            missingErrors += expQ.size();
            $display("%0t ns: %0d result(s) never arrived in %s", $time, expQ.size(), what);
            expQ.delete();
        end
    endtask

    task automatic sendIsolated(input koaPkg::operand_t a, input koaPkg::operand_t b,
                                input string what);
        @(posedge clk);
        drivePair(a, b);
        @(posedge clk);
        driveIdle();
        waitDrain(what);
    endtask

    // Output must keep the last product with valid_o low
    // Operands keep changing underneath while no pair is offered
    task automatic checkHeld(input string what);
        repeat (6) begin
            @(posedge clk);
            opA <= koaPkg::operand_t'($urandom);
            opB <= koaPkg::operand_t'($urandom);
            @(negedge clk);
            checkValid(validOut, 1'b0, what);
            checkProduct(productOut, lastProduct, what);
        end
    endtask

    // ====================
    // Directed tests
    // ====================

    task automatic verifyResetState();
        // First edge clears the registers
        @(posedge clk);
        @(negedge clk);
        while (porRstN !== 1'b1) begin
            checkValid(validOut, 1'b0, "valid_o in reset");
            checkProduct(productOut, '0, "product_o in reset");
            @(negedge clk);
        end
        repeat (4) begin
            checkValid(validOut, 1'b0, "valid_o after reset");
            checkProduct(productOut, '0, "product_o after reset");
            @(negedge clk);
        end
    endtask

    task automatic exerciseCorners();
        // Zero, one, all ones, split halves, carrying half sums
        koaPkg::operand_t cornerA [6] = '{24'h000000, 24'h000001, 24'hFFFFFF,
                                          24'hFFF000, 24'h800800, 24'hFFF801};
        koaPkg::operand_t cornerB [6] = '{24'hABCDEF, 24'hABCDEF, 24'hFFFFFF,
                                          24'h000FFF, 24'h800800, 24'h9FF7FF};
        for (int i = 0; i < 6; i++) begin
            sendIsolated(cornerA[i], cornerB[i], $sformatf("corner %0d", i));
            repeat (2) @(posedge clk);
        end
    endtask

    task automatic measureLatency();
        @(posedge clk);
        drivePair(24'h5A5A5A, 24'hA5A5A5);
        // Accepting edge
        @(posedge clk);
        driveIdle();
        @(negedge clk);
        for (int i = 0; i <= `KOA_LAT + 2; i++) begin
            checkValid(validOut, i == `KOA_LAT,
                       $sformatf("valid_o %0d cycles after accept", i));
            @(negedge clk);
        end
        waitDrain("latency test");
    endtask

    task automatic streamPairs();
        int startCount;
        int waited;
        startCount = resultCount;
        waited     = 0;
        fork
            begin
                for (int i = 0; i < StreamLen; i++) begin
                    @(posedge clk);
                    drivePair(koaPkg::operand_t'($urandom), koaPkg::operand_t'($urandom));
                end
                @(posedge clk);
                driveIdle();
            end
            begin
                // Results must form one unbroken run
                @(negedge clk);
                while (validOut !== 1'b1 && waited < DrainLimit) begin
                    @(negedge clk);
                    waited++;
                end
                if (validOut === 1'b1) begin
                    for (int i = 1; i < StreamLen; i++) begin
                        @(negedge clk);
                        checkValid(validOut, 1'b1, $sformatf("valid_o for stream result %0d", i));
                    end
                    @(negedge clk);
                    checkValid(validOut, 1'b0, "valid_o after stream");
                end
            end
        join
        waitDrain("streaming test");
        if (resultCount - startCount != StreamLen) begin
            missingErrors++;
            $display("%0t ns: stream gave %0d results instead of %0d", $time,
                     resultCount - startCount, StreamLen);
        end
    endtask

    task automatic holdBetweenPairs();
        sendIsolated(24'h3A5C71, 24'hC0FFEE, "hold test");
        checkHeld("held product 1");
        sendIsolated(24'h800001, 24'h7FFFFF, "hold test");
        checkHeld("held product 2");
    endtask

    task automatic resetMidStream();
        int lost;
        for (int i = 0; i < BurstLen; i++) begin
            @(posedge clk);
            drivePair(koaPkg::operand_t'($urandom), koaPkg::operand_t'($urandom));
        end
        @(posedge clk);
        driveIdle();
        midRstN <= 1'b0;
        // Next edge resets, pairs still queued were in flight
        @(posedge clk);
        @(negedge clk);
        checkValid(validOut, 1'b0, "valid_o at mid-stream reset");
        lost = expQ.size();
        expQ.delete();
        $display("%0t ns: mid-stream reset dropped %0d pairs in flight", $time, lost);
        @(posedge clk);
        midRstN <= 1'b1;
        // No stale result may follow
        repeat (3 * `KOA_LAT) begin
            @(negedge clk);
            checkValid(validOut, 1'b0, "valid_o after mid-stream reset");
            checkProduct(productOut, '0, "product_o after mid-stream reset");
        end
        sendIsolated(24'hC90FDB, 24'hB504F3, "recovery after reset");
    endtask

    // ====================
    // Run control
    // ====================

    initial begin
        void'($urandom(66266));
        validIn          = 1'b0;
        opA              = '0;
        opB              = '0;
        midRstN          = 1'b1;
        resultCount      = 0;
        valueErrors      = 0;
        missingErrors    = 0;
        unexpectedErrors = 0;
        lastProduct      = '0;
        verifyResetState();
        exerciseCorners();
        measureLatency();
        streamPairs();
        holdBetweenPairs();
        resetMidStream();
        repeat (4) @(negedge clk);
        $display("Errors: %0d wrong values, %0d missing results, %0d unexpected results",
                 valueErrors, missingErrors, unexpectedErrors);
        if (valueErrors + missingErrors + unexpectedErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog sized from the operation count
    initial begin
        #(WatchdogNs);
        $display("Watchdog expired after %0d ns, the run did not finish", WatchdogNs);
        $display("test failed");
        $finish;
    end

endmodule

/* testbench/tbClockGen.sv */
// Clock source and power-on reset for the testbench

`timescale 1ns/1ns

module tbClockGen #(
    parameter int PeriodNs    = 8,
    parameter int ResetCycles = 16
) (
    output logic clk_o,
    output logic rstN_o
);

    // Free-running clock, low at time zero
    initial clk_o = 1'b0;
    always #(PeriodNs / 2) clk_o = ~clk_o;

    // Reset low for the first ResetCycles rising edges
    initial begin
        rstN_o = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        rstN_o <= 1'b1;
    end

endmodule

/* verilog/koaSigMult.sv */
// Top level of the pipelined Karatsuba-Ofman significand multiplier
// Splitter, three lane multipliers and the combiner

`timescale 1ns/1ns

`include "koa_config.svh"

module koaSigMult (
    input  logic                  clk,
    input  logic                  rstN_i,
    input  logic                  valid_i,
    input  logic [`KOA_SW-1:0]    opA_i,
    input  logic [`KOA_SW-1:0]    opB_i,
    output logic                  valid_o,
    output logic [2*`KOA_SW-1:0]  product_o
);

    // Operand pairs from the splitter to the lanes
    koaLaneIf laneBus ();

    // Lane products from the lanes to the combiner
    koaProdIf prodBus ();

    // ====================
    // Operand split
    // ====================

    // One cycle, edge to registered lane operands after capture
    koaSplitter split0 (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .valid_i (valid_i),
        .opA_i   (opA_i),
        .opB_i   (opB_i),
        .laneBus (laneBus)
    );

    // ====================
    // Lane multipliers
    // ====================

    // Lane k serves entry k, in role order high, low, middle
    for (genvar k = 0; k < `KOA_LANES; k++) begin : genLane
        koaLaneMult #(
            .laneIdx (koaPkg::laneRole_e'(k))
        ) lane0 (
            .clk     (clk),
            .rstN_i  (rstN_i),
            .laneIn  (laneBus),
            .prodOut (prodBus)
        );
    end

    // ====================
    // Recombination
    // ====================

    // Last of the KOA_LAT stages
    koaCombiner comb0 (
        .clk       (clk),
        .rstN_i    (rstN_i),
        .prodBus   (prodBus),
        .valid_o   (valid_o),
        .product_o (product_o)
    );

endmodule

/* verilog/koaCombiner.sv */
// Karatsuba middle-term correction, final aligned sum and loaded result register

`timescale 1ns/1ns

`include "koa_config.svh"

module koaCombiner (
    input  logic             clk,
    input  logic             rstN_i,
    koaProdIf.sink           prodBus,
    output logic             valid_o,
    output koaPkg::product_t product_o
);

    // Lane products by role
    koaPkg::laneProd_t prodHigh;
    koaPkg::laneProd_t prodLow;
    koaPkg::laneProd_t prodMid;

    // Corrected middle term and the full sum
    koaPkg::laneProd_t midTerm;
    koaPkg::product_t  sum;

    assign prodHigh = prodBus.prod[koaPkg::LANE_HIGH];
    assign prodLow  = prodBus.prod[koaPkg::LANE_LOW];
    assign prodMid  = prodBus.prod[koaPkg::LANE_MID];

    // ====================
    // Correction and sum
    // ====================

    // (aH+aL)(bH+bL) - aH*bH - aL*bL leaves aH*bL + aL*bH
    // Never negative, so the unsigned difference is exact
    assign midTerm = prodMid - prodHigh - prodLow;

    // High term sits a full width up, middle term half a width up
    always_comb begin
        sum = (koaPkg::product_t'(prodHigh) << `KOA_SW)
            + (koaPkg::product_t'(midTerm) << `KOA_HALF)
            + koaPkg::product_t'(prodLow);
    end

    // ====================
    // Result register
    // ====================

    // Loads only on valid, otherwise holds the last product
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            valid_o   <= 1'b0;
            product_o <= '0;
        end else begin
            valid_o <= prodBus.valid;
            if (prodBus.valid) begin
                product_o <= sum;
            end
        end
    end

endmodule

/* verilog/koaLaneMult.sv */
// Two-stage pipelined multiplier serving one lane of the Karatsuba split

`timescale 1ns/1ns

`include "koa_config.svh"

module koaLaneMult #(
    parameter koaPkg::laneRole_e laneIdx = koaPkg::LANE_HIGH
) (
    input  logic   clk,
    input  logic   rstN_i,
    koaLaneIf.lane laneIn,
    koaProdIf.lane prodOut
);

    // Split of the B operand into lower and upper parts
    localparam int LoW = (`KOA_HALF + 1) / 2;
    localparam int HiW = `KOA_HALF + 1 - LoW;

    // This lane's operand pair
    koaPkg::laneOp_t opA;
    koaPkg::laneOp_t opB;
    logic [LoW-1:0]  bLo;
    logic [HiW-1:0]  bHi;

    // Stage 1 partial products
    logic [`KOA_HALF+LoW:0] ppLo;
    logic [`KOA_HALF+HiW:0] ppHi;
    logic                   validS1;

    // Stage 2 lane product
    koaPkg::laneProd_t prodS2;
    logic              validS2;

    assign opA = laneIn.opA[laneIdx];
    assign opB = laneIn.opB[laneIdx];
    assign bLo = opB[LoW-1:0];
    assign bHi = opB[`KOA_HALF:LoW];

    // Valid travels with the data through both stages
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            validS1 <= 1'b0;
            validS2 <= 1'b0;
        end else begin
            validS1 <= laneIn.valid;
            validS2 <= validS1;
        end
    end

    // Stage 1 is two narrow products, stage 2 the aligned sum
    always_ff @(posedge clk) begin
        ppLo   <= opA * bLo;
        ppHi   <= opA * bHi;
        prodS2 <= (koaPkg::laneProd_t'(ppHi) << LoW) + koaPkg::laneProd_t'(ppLo);
    end

    assign prodOut.prod[laneIdx] = prodS2;

    // All lanes run in lockstep, the high lane speaks for them
    if (laneIdx == koaPkg::LANE_HIGH) begin : genValid
        assign prodOut.valid = validS2;
    end

endmodule

/* verilog/koaSplitter.sv */
// Operand capture and high/low/half-sum lane operand generation

`timescale 1ns/1ns

`include "koa_config.svh"

module koaSplitter (
    input  logic               clk,
    input  logic               rstN_i,
    input  logic               valid_i,
    input  koaPkg::operand_t   opA_i,
    input  koaPkg::operand_t   opB_i,
    koaLaneIf.src              laneBus
);

    // Captured operands
    koaPkg::operand_t opAR;
    koaPkg::operand_t opBR;
    logic             validR;

    // Halves of the captured operands
    koaPkg::half_t aHi;
    koaPkg::half_t aLo;
    koaPkg::half_t bHi;
    koaPkg::half_t bLo;

    // Registered lane operands
    koaPkg::laneOp_t laneA [`KOA_LANES];
    koaPkg::laneOp_t laneB [`KOA_LANES];
    logic            laneValid;

    // ====================
    // Input capture
    // ====================

    // Valid bit has a reset, operand payload only loads
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            validR <= 1'b0;
        end else begin
            validR <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            opAR <= opA_i;
            opBR <= opB_i;
        end
    end

    assign aHi = opAR[`KOA_SW-1:`KOA_HALF];
    assign aLo = opAR[`KOA_HALF-1:0];
    assign bHi = opBR[`KOA_SW-1:`KOA_HALF];
    assign bLo = opBR[`KOA_HALF-1:0];

    // ====================
    // Lane operands
    // ====================

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            laneValid <= 1'b0;
        end else begin
            laneValid <= validR;
        end
    end

    always_ff @(posedge clk) begin
        if (validR) begin
            // Outer lanes get zero-extended halves
            laneA[koaPkg::LANE_HIGH] <= {1'b0, aHi};
            laneB[koaPkg::LANE_HIGH] <= {1'b0, bHi};
            laneA[koaPkg::LANE_LOW]  <= {1'b0, aLo};
            laneB[koaPkg::LANE_LOW]  <= {1'b0, bLo};
            // Exact half sums, carry lands in the extra bit
            laneA[koaPkg::LANE_MID]  <= {1'b0, aHi} + {1'b0, aLo};
            laneB[koaPkg::LANE_MID]  <= {1'b0, bHi} + {1'b0, bLo};
        end
    end

    assign laneBus.valid = laneValid;
    assign laneBus.opA   = laneA;
    assign laneBus.opB   = laneB;

endmodule

/* verilog/koaIf.sv */
// Lane operand bus and lane product bus between splitter, lanes and combiner

`timescale 1ns/1ns

`include "koa_config.svh"

// ====================
// Lane operand bus
// ====================

interface koaLaneIf;

    // Operand pairs valid for all lanes at once
    logic valid;

    // One A and one B operand per lane, indexed by lane role
    koaPkg::laneOp_t opA [`KOA_LANES];
    koaPkg::laneOp_t opB [`KOA_LANES];

    // Splitter side
    modport src (
        output valid,
        output opA,
        output opB
    );

    // Each lane picks out its own entry
    modport lane (
        input valid,
        input opA,
        input opB
    );

endinterface

// ====================
// Lane product bus
// ====================

interface koaProdIf;

    // Driven by the high lane only
    logic valid;

    // One product per lane, indexed by lane role
    koaPkg::laneProd_t prod [`KOA_LANES];

    // Lane side, lane k writes prod[k]
    modport lane (
        output valid,
        output prod
    );

    // Combiner side
    modport sink (
        input valid,
        input prod
    );

endinterface

/* verilog/koaPkg.sv */
// Operand, half, lane and product types plus the lane-role enum

`include "koa_config.svh"

package koaPkg;

    // One significand as it enters the multiplier
    typedef logic [`KOA_SW-1:0] operand_t;

    // One half of a significand
    typedef logic [`KOA_HALF-1:0] half_t;

    // Lane operand, one bit wider than a half
    // Holds the carry of a half sum so all lanes match
    typedef logic [`KOA_HALF:0] laneOp_t;

    // Lane product, twice the lane operand width
    typedef logic [2*(`KOA_HALF+1)-1:0] laneProd_t;

    // Exact product of two significands
    typedef logic [2*`KOA_SW-1:0] product_t;

    // Lane roles, also the index into the lane arrays
    typedef enum logic [1:0] {
        LANE_HIGH = 2'd0,
        LANE_LOW  = 2'd1,
        LANE_MID  = 2'd2
    } laneRole_e;

endpackage

/* verilog/koa_config.svh */
// Width, lane count and latency macros for the Karatsuba-Ofman significand multiplier

`ifndef KOA_CONFIG_SVH
`define KOA_CONFIG_SVH

// ====================
// Significand geometry
// ====================

// Significand width, must stay even
`define KOA_SW 24

// Width of one half of a significand
`define KOA_HALF (`KOA_SW / 2)

// High, low and middle lane multipliers
`define KOA_LANES 3

// Cycles from the accepting edge to valid_o
`define KOA_LAT 4

`endif
